// File: source/mdu_iq_config.svh
`ifndef MDU_IQ_CONFIG_SVH
`define MDU_IQ_CONFIG_SVH

// reservation entries in the issue queue
`define MDU_IQ_DEPTH 4

// operand and result width
`define MDU_XLEN 32

// reorder buffer tag width
`define MDU_TAG_W 5

// one restoring step per quotient bit
`define MDU_DIV_STEPS `MDU_XLEN

`endif

// File: source/mdu_pkg.sv
`include "mdu_iq_config.svh"

package mdu_pkg;

    // unsigned multiply/divide operations
    typedef enum logic [1:0] {
        op_mul   = 2'd0,
        op_mulhu = 2'd1,
        op_divu  = 2'd2,
        op_remu  = 2'd3
    } mdu_op_e;

    // arithmetic unit sequencing
    typedef enum logic [1:0] {
        st_idle = 2'd0,
        st_mul  = 2'd1,
        st_div  = 2'd2
    } mdu_state_e;

    // one instruction from the dispatch stage
    typedef struct packed {
        mdu_op_e                op;
        logic [`MDU_XLEN-1:0]   a;
        logic [`MDU_XLEN-1:0]   b;
        logic                   a_rdy;
        logic                   b_rdy;
        logic [`MDU_TAG_W-1:0]  a_tag;
        logic [`MDU_TAG_W-1:0]  b_tag;
        logic [`MDU_TAG_W-1:0]  dst_tag;
    } mdu_dispatch_t;

    // CDB broadcast seen by the queue
    typedef struct packed {
        logic                   valid;
        logic [`MDU_TAG_W-1:0]  tag;
        logic [`MDU_XLEN-1:0]   value;
    } mdu_snoop_t;

endpackage

// File: source/mdu_issue_if.sv
`timescale 1ns/10ps
`include "mdu_iq_config.svh"

interface mdu_issue_if import mdu_pkg::*; ();
    logic                   valid;
    logic                   ready;
    mdu_op_e                op;
    logic [`MDU_XLEN-1:0]   a;
    logic [`MDU_XLEN-1:0]   b;
    logic [`MDU_TAG_W-1:0]  tag;

    // execute register side
    modport issuer (output valid, output op, output a, output b, output tag, input ready);

    // arithmetic unit side
    modport unit (input valid, input op, input a, input b, input tag, output ready);

endinterface

// File: source/mdu_result_if.sv
`timescale 1ns/10ps
`include "mdu_iq_config.svh"

interface mdu_result_if ();
    logic                   valid;
    logic                   ready;
    logic [`MDU_TAG_W-1:0]  tag;
    logic [`MDU_XLEN-1:0]   result;

    // arithmetic unit drives the result
    modport producer (output valid, output tag, output result, input ready);

    // result queue takes it
    modport consumer (input valid, input tag, input result, output ready);

endinterface

// File: source/iq_entry.sv
`timescale 1ns/10ps
`include "mdu_iq_config.svh"

module iq_entry import mdu_pkg::*; (
    input  logic                clk,
    input  logic                reset_i,
    input  logic                flush_i,
    input  logic                write_i,
    input  mdu_dispatch_t       entry_i,
    input  mdu_snoop_t [1:0]    snoop_i,
    input  logic                release_i,
    output logic                empty_o,
    output logic                ready_o,
    output mdu_dispatch_t       entry_o
);
    logic           occupied_q;
    mdu_dispatch_t  entry_q;
    mdu_dispatch_t  entry_src;
    mdu_dispatch_t  entry_d;

    // new instruction on write, else the held one
    assign entry_src = write_i ? entry_i : entry_q;

    // capture any awaited operand from either snoop bus
    always_comb begin
        entry_d = entry_src;
        for (int s = 0; s < 2; s++) begin
            if (snoop_i[s].valid && !entry_src.a_rdy && snoop_i[s].tag == entry_src.a_tag) begin
                entry_d.a     = snoop_i[s].value;
                entry_d.a_rdy = 1'b1;
            end
            if (snoop_i[s].valid && !entry_src.b_rdy && snoop_i[s].tag == entry_src.b_tag) begin
                entry_d.b     = snoop_i[s].value;
                entry_d.b_rdy = 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i || flush_i) begin
            occupied_q <= 1'b0;
        end else if (write_i) begin
            occupied_q <= 1'b1;
        end else if (release_i) begin
            occupied_q <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (write_i || occupied_q) begin
            entry_q <= entry_d;
        end
    end

    assign empty_o = !occupied_q;
    // both sources present, eligible for issue
    assign ready_o = occupied_q && entry_q.a_rdy && entry_q.b_rdy;
    assign entry_o = entry_q;

endmodule

// File: source/mdu_issue_ctrl.sv
`timescale 1ns/10ps
`include "mdu_iq_config.svh"

module mdu_issue_ctrl import mdu_pkg::*; (
    input  logic                                clk,
    input  logic                                reset_i,
    input  logic                                flush_i,
    input  logic [1:0]                          p_valid_i,
    output logic                                p_ready_o,
    input  logic [`MDU_IQ_DEPTH-1:0]            empty_i,
    input  logic [`MDU_IQ_DEPTH-1:0]            ready_i,
    input  mdu_dispatch_t [`MDU_IQ_DEPTH-1:0]   entries_i,
    output logic [`MDU_IQ_DEPTH-1:0]            write_o,
    output logic [`MDU_IQ_DEPTH-1:0]            write_slot_o,
    output logic [`MDU_IQ_DEPTH-1:0]            release_o,
    mdu_issue_if.issuer                         iss
);
    localparam int CNT_W = $clog2(`MDU_IQ_DEPTH + 1);

    logic [CNT_W-1:0]           free_cnt_q;
    logic [CNT_W-1:0]           free_cnt_d;
    logic [1:0]                 accept;
    logic [`MDU_IQ_DEPTH-1:0]   slot0_oh;
    logic [`MDU_IQ_DEPTH-1:0]   slot1_oh;
    logic [`MDU_IQ_DEPTH-1:0]   pick_oh;
    mdu_dispatch_t              pick_entry;
    logic                       any_ready;
    logic                       exec_ready;
    logic                       issue_fire;
    logic                       exec_valid_q;
    mdu_op_e                    exec_op_q;
    logic [`MDU_XLEN-1:0]       exec_a_q;
    logic [`MDU_XLEN-1:0]       exec_b_q;
    logic [`MDU_TAG_W-1:0]      exec_tag_q;

    assign accept = p_valid_i & {2{p_ready_o}};

    // slot 0 from the bottom, slot 1 from the top
    always_comb begin
        slot0_oh = '0;
        slot1_oh = '0;
        for (int i = `MDU_IQ_DEPTH - 1; i >= 0; i--) begin
            if (empty_i[i]) begin
                slot0_oh    = '0;
                slot0_oh[i] = 1'b1;
            end
        end
        for (int i = 0; i < `MDU_IQ_DEPTH; i++) begin
            if (empty_i[i]) begin
                slot1_oh    = '0;
                slot1_oh[i] = 1'b1;
            end
        end
    end

    assign write_o      = (accept[0] ? slot0_oh : '0) | (accept[1] ? slot1_oh : '0);
    assign write_slot_o = accept[1] ? slot1_oh : '0;

    // lowest ready entry wins
    always_comb begin
        pick_oh    = '0;
        pick_entry = entries_i[0];
        for (int i = `MDU_IQ_DEPTH - 1; i >= 0; i--) begin
            if (ready_i[i]) begin
                pick_oh    = '0;
                pick_oh[i] = 1'b1;
                pick_entry = entries_i[i];
            end
        end
    end

    assign any_ready  = |ready_i;
    assign exec_ready = !exec_valid_q || iss.ready;
    assign issue_fire = any_ready && exec_ready;
    assign release_o  = issue_fire ? pick_oh : '0;

    assign free_cnt_d = free_cnt_q - CNT_W'(accept[0]) - CNT_W'(accept[1]) + CNT_W'(issue_fire);

    // ready only with room for a full pair next cycle
    always_ff @(posedge clk) begin
        if (reset_i) begin
            free_cnt_q <= CNT_W'(`MDU_IQ_DEPTH);
            p_ready_o  <= 1'b0;
        end else if (flush_i) begin
            free_cnt_q <= CNT_W'(`MDU_IQ_DEPTH);
            p_ready_o  <= 1'b1;
        end else begin
            free_cnt_q <= free_cnt_d;
            p_ready_o  <= free_cnt_d >= CNT_W'(2);
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i || flush_i) begin
            exec_valid_q <= 1'b0;
        end else if (exec_ready) begin
            exec_valid_q <= any_ready;
        end
    end

    always_ff @(posedge clk) begin
        if (issue_fire) begin
            exec_op_q  <= pick_entry.op;
            exec_a_q   <= pick_entry.a;
            exec_b_q   <= pick_entry.b;
            exec_tag_q <= pick_entry.dst_tag;
        end
    end

    assign iss.valid = exec_valid_q;
    assign iss.op    = exec_op_q;
    assign iss.a     = exec_a_q;
    assign iss.b     = exec_b_q;
    assign iss.tag   = exec_tag_q;

endmodule

// File: source/mdu_unit.sv
`timescale 1ns/10ps
`include "mdu_iq_config.svh"

module mdu_unit import mdu_pkg::*; (
    input  logic                clk,
    input  logic                reset_i,
    input  logic                flush_i,
    mdu_issue_if.unit           iss,
    mdu_result_if.producer      res
);
    localparam int CNT_W = $clog2(`MDU_DIV_STEPS + 1);
    localparam int PW    = 2 * `MDU_XLEN;

    mdu_state_e             state_q;
    mdu_op_e                op_q;
    logic [`MDU_TAG_W-1:0]  tag_q;
    // multiplicand, or dividend shifting out while quotient shifts in
    logic [`MDU_XLEN-1:0]   opa_q;
    logic [`MDU_XLEN-1:0]   opb_q;
    logic [`MDU_XLEN-1:0]   rem_q;
    logic [PW-1:0]          prod_q;
    logic [CNT_W-1:0]       cnt_q;
    logic [`MDU_XLEN:0]     trial;
    logic [`MDU_XLEN:0]     diff;
    logic                   res_valid_q;
    logic [`MDU_XLEN-1:0]   res_result_q;

    // one restoring step
    assign trial = {rem_q, opa_q[`MDU_XLEN-1]};
    assign diff  = trial - {1'b0, opb_q};

    always_ff @(posedge clk) begin
        if (reset_i || flush_i) begin
            state_q     <= st_idle;
            res_valid_q <= 1'b0;
        end else if (res_valid_q) begin
            // hold until the result queue takes it
            if (res.ready) begin
                res_valid_q <= 1'b0;
                state_q     <= st_idle;
            end
        end else begin
            case (state_q)
                st_idle: begin
                    if (iss.valid) begin
                        state_q <= (iss.op == op_mul || iss.op == op_mulhu) ? st_mul : st_div;
                    end
                end
                st_mul: begin
                    if (cnt_q != '0) begin
                        res_valid_q <= 1'b1;
                    end
                end
                st_div: begin
                    if (cnt_q == CNT_W'(`MDU_DIV_STEPS)) begin
                        res_valid_q <= 1'b1;
                    end
                end
                default: state_q <= st_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        case (state_q)
            st_idle: begin
                if (iss.valid) begin
                    op_q  <= iss.op;
                    tag_q <= iss.tag;
                    opa_q <= iss.a;
                    opb_q <= iss.b;
                    rem_q <= '0;
                    cnt_q <= '0;
                end
            end
            st_mul: begin
                if (!res_valid_q) begin
                    if (cnt_q == '0) begin
                        prod_q <= PW'(opa_q) * PW'(opb_q);
                        cnt_q  <= cnt_q + 1'b1;
                    end else begin
                        res_result_q <= (op_q == op_mulhu) ? prod_q[PW-1:`MDU_XLEN]
                                                           : prod_q[`MDU_XLEN-1:0];
                    end
                end
            end
            st_div: begin
                if (!res_valid_q) begin
                    if (cnt_q != CNT_W'(`MDU_DIV_STEPS)) begin
                        // zero divisor falls out as all-ones quotient
                        if (trial >= {1'b0, opb_q}) begin
                            rem_q <= diff[`MDU_XLEN-1:0];
                            opa_q <= {opa_q[`MDU_XLEN-2:0], 1'b1};
                        end else begin
                            rem_q <= trial[`MDU_XLEN-1:0];
                            opa_q <= {opa_q[`MDU_XLEN-2:0], 1'b0};
                        end
                        cnt_q <= cnt_q + 1'b1;
                    end else begin
                        res_result_q <= (op_q == op_divu) ? opa_q : rem_q;
                    end
                end
            end
            default: begin
            end
        endcase
    end

    assign iss.ready  = (state_q == st_idle);
    assign res.valid  = res_valid_q;
    assign res.tag    = tag_q;
    assign res.result = res_result_q;

endmodule

// File: source/result_fifo.sv
`timescale 1ns/10ps
`include "mdu_iq_config.svh"

module result_fifo (
    input  logic                    clk,
    input  logic                    reset_i,
    input  logic                    flush_i,
    mdu_result_if.consumer          res,
    output logic                    cdb_valid_o,
    input  logic                    cdb_ready_i,
    output logic [`MDU_TAG_W-1:0]   cdb_tag_o,
    output logic [`MDU_XLEN-1:0]    cdb_result_o
);
    logic [`MDU_TAG_W-1:0]  tag_mem [2];
    logic [`MDU_XLEN-1:0]   result_mem [2];
    logic                   wr_ptr_q;
    logic                   rd_ptr_q;
    logic [1:0]             count_q;
    logic                   push;
    logic                   pop;

    assign res.ready   = (count_q != 2'd2);
    assign cdb_valid_o = (count_q != 2'd0);
    assign push        = res.valid && res.ready;
    assign pop         = cdb_valid_o && cdb_ready_i;

    always_ff @(posedge clk) begin
        if (reset_i || flush_i) begin
            wr_ptr_q <= 1'b0;
            rd_ptr_q <= 1'b0;
            count_q  <= 2'd0;
        end else begin
            if (push) begin
                wr_ptr_q <= !wr_ptr_q;
            end
            if (pop) begin
                rd_ptr_q <= !rd_ptr_q;
            end
            count_q <= count_q + {1'b0, push} - {1'b0, pop};
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            tag_mem[wr_ptr_q]    <= res.tag;
            result_mem[wr_ptr_q] <= res.result;
        end
    end

    // head stays put until the arbiter accepts it
    assign cdb_tag_o    = tag_mem[rd_ptr_q];
    assign cdb_result_o = result_mem[rd_ptr_q];

endmodule

// File: source/mdu_subsys_top.sv
`timescale 1ns/10ps
`include "mdu_iq_config.svh"

module mdu_subsys_top import mdu_pkg::*; (
    input  logic                    clk,
    input  logic                    reset_i,
    input  logic                    flush_i,
    input  logic [1:0]              p_valid_i,
    output logic                    p_ready_o,
    input  mdu_dispatch_t           p_inst0_i,
    input  mdu_dispatch_t           p_inst1_i,
    input  mdu_snoop_t              snoop0_i,
    input  mdu_snoop_t              snoop1_i,
    output logic                    cdb_valid_o,
    input  logic                    cdb_ready_i,
    output logic [`MDU_TAG_W-1:0]   cdb_tag_o,
    output logic [`MDU_XLEN-1:0]    cdb_result_o
);
    logic [`MDU_IQ_DEPTH-1:0]           empty;
    logic [`MDU_IQ_DEPTH-1:0]           ready;
    logic [`MDU_IQ_DEPTH-1:0]           write;
    logic [`MDU_IQ_DEPTH-1:0]           write_slot;
    logic [`MDU_IQ_DEPTH-1:0]           release_sel;
    mdu_dispatch_t [`MDU_IQ_DEPTH-1:0]  entries;
    mdu_snoop_t [1:0]                   snoop;

    mdu_issue_if    iss_if ();
    mdu_result_if   res_if ();

    assign snoop[0] = snoop0_i;
    assign snoop[1] = snoop1_i;

    for (genvar i = 0; i < `MDU_IQ_DEPTH; i++) begin : g_entry
        mdu_dispatch_t entry_in;

        // each entry is written from one dispatch slot
        assign entry_in = write_slot[i] ? p_inst1_i : p_inst0_i;

        iq_entry u_entry (
            .clk       (clk),
            .reset_i   (reset_i),
            .flush_i   (flush_i),
            .write_i   (write[i]),
            .entry_i   (entry_in),
            .snoop_i   (snoop),
            .release_i (release_sel[i]),
            .empty_o   (empty[i]),
            .ready_o   (ready[i]),
            .entry_o   (entries[i])
        );
    end

    mdu_issue_ctrl u_ctrl (
        .clk          (clk),
        .reset_i      (reset_i),
        .flush_i      (flush_i),
        .p_valid_i    (p_valid_i),
        .p_ready_o    (p_ready_o),
        .empty_i      (empty),
        .ready_i      (ready),
        .entries_i    (entries),
        .write_o      (write),
        .write_slot_o (write_slot),
        .release_o    (release_sel),
        .iss          (iss_if.issuer)
    );

    mdu_unit u_unit (
        .clk     (clk),
        .reset_i (reset_i),
        .flush_i (flush_i),
        .iss     (iss_if.unit),
        .res     (res_if.producer)
    );

    result_fifo u_fifo (
        .clk          (clk),
        .reset_i      (reset_i),
        .flush_i      (flush_i),
        .res          (res_if.consumer),
        .cdb_valid_o  (cdb_valid_o),
        .cdb_ready_i  (cdb_ready_i),
        .cdb_tag_o    (cdb_tag_o),
        .cdb_result_o (cdb_result_o)
    );

endmodule

// File: testbench/tb_mdu_subsys.sv
`timescale 1ns/10ps
`include "mdu_iq_config.svh"

module tb_mdu_subsys import mdu_pkg::*; ();
    localparam int NUM_INSTR   = 30;
    localparam int CYCLE_LIMIT = 40 * NUM_INSTR + 200;
    localparam int NUM_TAGS    = 1 << `MDU_TAG_W;

    logic                   clk;
    logic                   reset_i;
    logic                   flush_i;
    logic [1:0]             p_valid_i;
    logic                   p_ready_o;
    mdu_dispatch_t          p_inst0_i;
    mdu_dispatch_t          p_inst1_i;
    mdu_snoop_t             snoop0_i;
    mdu_snoop_t             snoop1_i;
    logic                   cdb_valid_o;
    logic                   cdb_ready_i;
    logic [`MDU_TAG_W-1:0]  cdb_tag_o;
    logic [`MDU_XLEN-1:0]   cdb_result_o;

    integer                 seed;
    int                     cycle_count;
    int                     outstanding;
    int                     next_tag;
    int                     released_cycles;
    bit                     pending [NUM_TAGS];
    logic [`MDU_XLEN-1:0]   model [NUM_TAGS];
    // CDB outputs as seen at the falling edge
    logic                   snap_valid;
    logic                   snap_ready;
    logic [`MDU_TAG_W-1:0]  snap_tag;
    logic [`MDU_XLEN-1:0]   snap_result;
    // head that must still be there one cycle later
    logic                   hold_check;
    logic [`MDU_TAG_W-1:0]  hold_tag;
    logic [`MDU_XLEN-1:0]   hold_result;
    logic                   flush_seen;
    bit                     ready_random;
    bit                     ready_hold;
    int                     stretch;
    bit                     quiet_window;
    bit                     full_window;
    logic [`MDU_XLEN-1:0]   va;
    logic [`MDU_XLEN-1:0]   vb;
    logic [`MDU_XLEN-1:0]   vc;
    logic [`MDU_XLEN-1:0]   vd;
    logic [`MDU_XLEN-1:0]   fill_val [4];

    mdu_subsys_top dut0 (
        .clk          (clk),
        .reset_i      (reset_i),
        .flush_i      (flush_i),
        .p_valid_i    (p_valid_i),
        .p_ready_o    (p_ready_o),
        .p_inst0_i    (p_inst0_i),
        .p_inst1_i    (p_inst1_i),
        .snoop0_i     (snoop0_i),
        .snoop1_i     (snoop1_i),
        .cdb_valid_o  (cdb_valid_o),
        .cdb_ready_i  (cdb_ready_i),
        .cdb_tag_o    (cdb_tag_o),
        .cdb_result_o (cdb_result_o)
    );

    always #20 clk = ~clk;

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("STATUS: FAIL");
        $fatal(1, "run stopped at first error");
    endtask

    task automatic step_cycle();
        @(posedge clk);
        #2;
    endtask

    function automatic logic [`MDU_XLEN-1:0] rand_word();
        rand_word = $random(seed);
    endfunction

    function automatic logic [`MDU_XLEN-1:0] rand_divisor();
        logic [`MDU_XLEN-1:0] r;
        logic [`MDU_XLEN-1:0] s;
        r = rand_word();
        s = rand_word();
        return r >> s[4:0];
    endfunction

    function automatic mdu_op_e random_op();
        logic [`MDU_XLEN-1:0] r;
        r = rand_word();
        return mdu_op_e'(r[1:0]);
    endfunction

    // unsigned low/high product, quotient and remainder
    function automatic logic [`MDU_XLEN-1:0] expected_result(input mdu_op_e op,
            input logic [`MDU_XLEN-1:0] a, input logic [`MDU_XLEN-1:0] b);
        logic [2*`MDU_XLEN-1:0] prod;
        prod = {{`MDU_XLEN{1'b0}}, a} * {{`MDU_XLEN{1'b0}}, b};
        case (op)
            op_mul:   return prod[`MDU_XLEN-1:0];
            op_mulhu: return prod[2*`MDU_XLEN-1:`MDU_XLEN];
            op_divu:  return (b == '0) ? '1 : a / b;
            default:  return (b == '0) ? a : a % b;
        endcase
    endfunction

    // next free tag, expected value recorded up front
    function automatic mdu_dispatch_t new_inst(input mdu_op_e op,
            input logic [`MDU_XLEN-1:0] a, input logic [`MDU_XLEN-1:0] b,
            input logic a_wait, input logic b_wait, input logic [`MDU_TAG_W-1:0] src_tag);
        mdu_dispatch_t          inst;
        logic [`MDU_TAG_W-1:0]  dst;
        dst = `MDU_TAG_W'(next_tag);
        next_tag++;
        model[dst] = expected_result(op, a, b);
        pending[dst] = 1'b1;
        outstanding++;
        inst.op = op;
        // a missing operand carries junk until the snoop fills it
        inst.a = a_wait ? ~a : a;
        inst.b = b_wait ? ~b : b;
        inst.a_rdy = !a_wait;
        inst.b_rdy = !b_wait;
        inst.a_tag = src_tag;
        inst.b_tag = src_tag;
        inst.dst_tag = dst;
        return inst;
    endfunction

    task automatic dispatch_one(input mdu_dispatch_t inst);
        while (!p_ready_o) step_cycle();
        p_inst0_i = inst;
        p_valid_i = 2'b01;
        step_cycle();
        p_valid_i = 2'b00;
    endtask

    task automatic dispatch_two(input mdu_dispatch_t inst0, input mdu_dispatch_t inst1);
        while (!p_ready_o) step_cycle();
        p_inst0_i = inst0;
        p_inst1_i = inst1;
        p_valid_i = 2'b11;
        step_cycle();
        p_valid_i = 2'b00;
    endtask

    task automatic broadcast_snoops(input logic v0, input logic [`MDU_TAG_W-1:0] t0,
            input logic [`MDU_XLEN-1:0] d0, input logic v1,
            input logic [`MDU_TAG_W-1:0] t1, input logic [`MDU_XLEN-1:0] d1);
        snoop0_i = '{valid: v0, tag: t0, value: d0};
        snoop1_i = '{valid: v1, tag: t1, value: d1};
        step_cycle();
        snoop0_i = '0;
        snoop1_i = '0;
    endtask

    task automatic wait_drain();
        while (outstanding != 0) step_cycle();
    endtask

    // CDB arbiter model, random stretches of ready or not
    always @(posedge clk) begin
        #1;
        if (!ready_random) begin
            cdb_ready_i = ready_hold;
        end else if (stretch == 0) begin
            cdb_ready_i = rand_word() > 32'h7fff_ffff;
            stretch = 1 + int'(rand_word() % 8);
        end else begin
            stretch--;
        end
    end

    always @(negedge clk) begin
        snap_valid  = cdb_valid_o && !reset_i;
        snap_ready  = cdb_ready_i;
        snap_tag    = cdb_tag_o;
        snap_result = cdb_result_o;
    end

    // scoreboard update just after the handshake edge
    always @(posedge clk) begin
        #1;
        flush_seen = flush_i;
        if (reset_i) begin
            released_cycles = 0;
        end else if (released_cycles < 2) begin
            released_cycles++;
        end
        hold_check  = snap_valid && !snap_ready && !flush_i;
        hold_tag    = snap_tag;
        hold_result = snap_result;
        if (snap_valid && snap_ready && !flush_i) begin
            pending[snap_tag] = 1'b0;
            outstanding--;
        end
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count > CYCLE_LIMIT) begin
            abort_run($sformatf("timeout after %0d cycles with %0d results outstanding",
                                cycle_count, outstanding));
        end
    end

    a_reset_quiet: assert property (@(negedge clk) reset_i |-> !cdb_valid_o)
        else abort_run("cdb_valid_o was high during reset");

    a_ready_after_reset: assert property (@(negedge clk) released_cycles == 1 |-> p_ready_o)
        else abort_run("p_ready_o did not rise one cycle after reset");

    a_tag_known: assert property (@(negedge clk) disable iff (reset_i)
        (cdb_valid_o && cdb_ready_i) |-> pending[cdb_tag_o])
        else abort_run($sformatf("tag %0d returned at %0d ns but was not outstanding",
                                 cdb_tag_o, $time));

    a_result_value: assert property (@(negedge clk) disable iff (reset_i)
        (cdb_valid_o && cdb_ready_i) |-> cdb_result_o == model[cdb_tag_o])
        else abort_run($sformatf("Error at %0d ns: cdb_result_o = 0x%08h, expected 0x%08h",
                                 $time, cdb_result_o, model[cdb_tag_o]));

    a_head_valid: assert property (@(negedge clk) disable iff (reset_i)
        hold_check |-> cdb_valid_o)
        else abort_run("cdb_valid_o dropped before the arbiter accepted the result");

    a_head_tag: assert property (@(negedge clk) disable iff (reset_i)
        hold_check |-> cdb_tag_o == hold_tag)
        else abort_run($sformatf("Error at %0d ns: cdb_tag_o = %0d, expected %0d",
                                 $time, cdb_tag_o, hold_tag));

    a_head_result: assert property (@(negedge clk) disable iff (reset_i)
        hold_check |-> cdb_result_o == hold_result)
        else abort_run($sformatf("Error at %0d ns: cdb_result_o = 0x%08h, expected 0x%08h",
                                 $time, cdb_result_o, hold_result));

    a_flush_clears: assert property (@(negedge clk) flush_seen |-> !cdb_valid_o)
        else abort_run("cdb_valid_o was high in the cycle after a flush");

    a_no_early_result: assert property (@(negedge clk) quiet_window |-> !cdb_valid_o)
        else abort_run("a result appeared while its operands were still missing");

    a_full_blocks: assert property (@(negedge clk) full_window |-> !p_ready_o)
        else abort_run("p_ready_o stayed high with the queue full");

    initial begin
        seed = 27;
        clk = 1'b0;
        reset_i = 1'b1;
        flush_i = 1'b0;
        p_valid_i = 2'b00;
        p_inst0_i = '0;
        p_inst1_i = '0;
        snoop0_i = '0;
        snoop1_i = '0;
        cdb_ready_i = 1'b1;
        ready_hold = 1'b1;
        ready_random = 1'b0;
        stretch = 0;
        quiet_window = 1'b0;
        full_window = 1'b0;
        next_tag = 0;
        outstanding = 0;
        cycle_count = 0;
        released_cycles = 0;
        hold_check = 1'b0;
        flush_seen = 1'b0;
        snap_valid = 1'b0;
        snap_ready = 1'b0;
        repeat (5) @(posedge clk);
        #2;
        reset_i = 1'b0;
        while (!p_ready_o) step_cycle();

        // every opcode alone, divides by zero
        dispatch_one(new_inst(op_mul, rand_word(), rand_word(), 1'b0, 1'b0, '0));
        dispatch_one(new_inst(op_mulhu, rand_word(), rand_word(), 1'b0, 1'b0, '0));
        dispatch_one(new_inst(op_divu, rand_word(), '0, 1'b0, 1'b0, '0));
        dispatch_one(new_inst(op_remu, rand_word(), '0, 1'b0, 1'b0, '0));
        for (int k = 0; k < 4; k++) begin
            dispatch_two(new_inst(mdu_op_e'(2'(k)), rand_word(), rand_divisor(), 1'b0, 1'b0, '0),
                         new_inst(mdu_op_e'(2'(3 - k)), rand_word(), rand_word(), 1'b0, 1'b0, '0));
        end
        wait_drain();

        // operands arriving over the snoop buses
        va = rand_word();
        vb = rand_word();
        vc = rand_word();
        vd = rand_divisor();
        dispatch_two(new_inst(op_mul, va, vb, 1'b1, 1'b0, 5'd20),
                     new_inst(op_remu, vc, vd, 1'b0, 1'b1, 5'd21));
        quiet_window = 1'b1;
        repeat (10) step_cycle();
        quiet_window = 1'b0;
        broadcast_snoops(1'b0, '0, '0, 1'b1, 5'd20, va);
        broadcast_snoops(1'b1, 5'd21, vd, 1'b0, '0, '0);
        wait_drain();

        // back-pressure from the arbiter
        ready_random = 1'b1;
        for (int k = 0; k < 3; k++) begin
            dispatch_two(new_inst(random_op(), rand_word(), rand_divisor(), 1'b0, 1'b0, '0),
                         new_inst(random_op(), rand_word(), rand_divisor(), 1'b0, 1'b0, '0));
        end
        wait_drain();
        ready_random = 1'b0;

        // fill every entry with waiting instructions
        for (int k = 0; k < 4; k++) begin
            fill_val[k] = rand_word();
        end
        dispatch_two(new_inst(random_op(), fill_val[0], rand_divisor(), 1'b1, 1'b0, 5'd24),
                     new_inst(random_op(), fill_val[1], rand_divisor(), 1'b1, 1'b0, 5'd25));
        dispatch_two(new_inst(random_op(), fill_val[2], rand_divisor(), 1'b1, 1'b0, 5'd26),
                     new_inst(random_op(), fill_val[3], rand_divisor(), 1'b1, 1'b0, 5'd27));
        quiet_window = 1'b1;
        full_window = 1'b1;
        repeat (10) step_cycle();
        quiet_window = 1'b0;
        full_window = 1'b0;
        broadcast_snoops(1'b1, 5'd24, fill_val[0], 1'b1, 5'd25, fill_val[1]);
        broadcast_snoops(1'b1, 5'd26, fill_val[2], 1'b1, 5'd27, fill_val[3]);
        while (!p_ready_o) step_cycle();
        wait_drain();

        // flush with results queued, one dividing and one still waiting
        ready_hold = 1'b0;
        dispatch_two(new_inst(op_mul, rand_word(), rand_word(), 1'b0, 1'b0, '0),
                     new_inst(op_mulhu, rand_word(), rand_word(), 1'b0, 1'b0, '0));
        while (!cdb_valid_o) step_cycle();
        vd = rand_word();
        dispatch_two(new_inst(op_divu, rand_word(), rand_divisor(), 1'b0, 1'b0, '0),
                     new_inst(op_mul, vd, rand_word(), 1'b1, 1'b0, 5'd30));
        repeat (8) step_cycle();
        flush_i = 1'b1;
        foreach (pending[t]) begin
            pending[t] = 1'b0;
        end
        outstanding = 0;
        step_cycle();
        flush_i = 1'b0;
        ready_hold = 1'b1;
        // the flushed waiter must not wake up
        broadcast_snoops(1'b1, 5'd30, vd, 1'b0, '0, '0);
        dispatch_two(new_inst(random_op(), rand_word(), rand_divisor(), 1'b0, 1'b0, '0),
                     new_inst(random_op(), rand_word(), rand_divisor(), 1'b0, 1'b0, '0));
        wait_drain();
        repeat (5) step_cycle();

        if (outstanding == 0 && next_tag == NUM_INSTR) begin
            $display("STATUS: PASS");
            $finish;
        end else begin
            $display("run ended with %0d results missing after %0d dispatches",
                     outstanding, next_tag);
            $display("STATUS: FAIL");
            $fatal(1, "run ended incomplete");
        end
    end

endmodule

// File: build.f
+incdir+source
source/mdu_pkg.sv
source/mdu_issue_if.sv
source/mdu_result_if.sv
source/iq_entry.sv
source/mdu_issue_ctrl.sv
source/mdu_unit.sv
source/result_fifo.sv
source/mdu_subsys_top.sv
testbench/tb_mdu_subsys.sv

// File: run_sim.sh
#!/usr/bin/env bash
set -u

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --assert -Wno-fatal -f build.f --top-module tb_mdu_subsys \
    -Mdir "$BUILD_DIR" -o sim_tb
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

"./$BUILD_DIR/sim_tb" > "$LOG" 2>&1
sim_status=$?
cat "$LOG"
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if grep -q "^STATUS: PASS$" "$LOG"; then
    echo "pass message found in $LOG"
    exit 0
fi

echo "pass message missing from $LOG"
exit 1
